/* common/bu_pkg.sv */
package bu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Instruction word width
  localparam int ILEN = 32;

  // Exception vector width
  localparam int EXC_SIZE = 16;

  // Bit index of the misaligned instruction cause
  localparam int CAUSE_MISALIGNED_INSTR = 0;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Raw instruction word
  typedef logic [ILEN-1:0] instr_t;

  // One bit per exception cause
  typedef logic [EXC_SIZE-1:0] exc_t;

  // Saturating 2-bit counter
  // Bit 1 set means predict taken
  typedef logic [1:0] bp_cnt_t;

  // Major opcode, instr[6:2]
  typedef logic [4:0] opcode_t;

  // Branch condition select, instr[14:12]
  typedef logic [2:0] funct3_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Control flow opcodes
  localparam opcode_t OPC_JAL     = 5'b11011;
  localparam opcode_t OPC_JALR    = 5'b11001;
  localparam opcode_t OPC_BRANCH  = 5'b11000;

  // FENCE and FENCE.I live here
  localparam opcode_t OPC_MISCMEM = 5'b00011;

  // Conditional branch kinds
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Complete FENCE.I word
  // rd, rs1 and imm all zero
  localparam instr_t FENCE_I_WORD = 32'h0000_100F;

  ////////////////////////////////////////////////////////////
  // Predictor
  ////////////////////////////////////////////////////////////

  // Weakly not taken
  localparam bp_cnt_t BP_CNT_INIT = 2'b01;

endpackage

/* src/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit #(
  parameter int              XLEN           = 32,
  parameter logic [XLEN-1:0] PC_INIT        = 'h200,
  parameter bit              HAS_RVC        = 0,
  parameter int              BP_GLOBAL_BITS = 2
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ex_stall,
  input  logic                      st_flush,
  input  logic [XLEN-1:0]           id_pc,
  input  bu_pkg::instr_t            id_instr,
  input  logic                      id_bubble,
  input  bu_pkg::bp_cnt_t           id_bp_predict,
  input  logic [XLEN-1:0]           opA,
  input  logic [XLEN-1:0]           opB,
  input  bu_pkg::exc_t              id_exception,
  input  bu_pkg::exc_t              ex_exception,
  input  bu_pkg::exc_t              mem_exception,
  input  bu_pkg::exc_t              wb_exception,
  input  logic                      du_stall,
  input  logic                      du_flush,
  input  logic                      du_we_pc,
  input  logic [XLEN-1:0]           du_dato,
  output logic [XLEN-1:0]           bu_nxt_pc,
  output logic                      bu_flush,
  output logic                      bu_cacheflush,
  output bu_pkg::exc_t              bu_exception,
  output logic                      bu_bp_update,
  output logic [XLEN-1:0]           bu_bp_pc,
  output logic                      bu_bp_btaken,
  output bu_pkg::bp_cnt_t           bu_bp_predict,
  output logic [BP_GLOBAL_BITS-1:0] bu_bp_history
);
  import bu_pkg::*;

  opcode_t                 opcode;
  funct3_t                 funct3;
  logic [XLEN-1:0]         imm_j;
  logic [XLEN-1:0]         imm_b;
  logic [XLEN-1:0]         nxt_pc;
  logic                    btaken;
  logic                    bp_upd;
  logic                    pipeflush;
  logic                    cacheflush;
  logic                    is_cf;
  logic                    misaligned;
  logic                    du_wrote_pc;
  // Extra bit holds the newest outcome
  logic [BP_GLOBAL_BITS:0] bp_history;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign opcode = id_instr[6:2];
  assign funct3 = id_instr[14:12];

  // Sign extended J and B immediates
  assign imm_j = {{(XLEN-20){id_instr[31]}}, id_instr[19:12], id_instr[20],
                  id_instr[30:21], 1'b0};
  assign imm_b = {{(XLEN-12){id_instr[31]}}, id_instr[7], id_instr[30:25],
                  id_instr[11:8], 1'b0};

  // Resolution of the instruction in decode
  always_comb begin
    btaken     = 1'b0;
    bp_upd     = 1'b0;
    pipeflush  = 1'b0;
    cacheflush = 1'b0;
    is_cf      = 1'b0;
    nxt_pc     = id_pc + XLEN'(4);
    if (!id_bubble) begin
      case (opcode)
        // Fetch already follows JAL
        OPC_JAL: begin
          btaken = 1'b1;
          is_cf  = 1'b1;
          nxt_pc = id_pc + imm_j;
        end
        // Register target with LSB forced low
        OPC_JALR: begin
          btaken    = 1'b1;
          is_cf     = 1'b1;
          pipeflush = 1'b1;
          nxt_pc    = (opA + opB) & ~XLEN'(1);
        end
        OPC_BRANCH: begin
          bp_upd = 1'b1;
          is_cf  = 1'b1;
          case (funct3)
            F3_BEQ:  btaken = (opA == opB);
            F3_BNE:  btaken = (opA != opB);
            F3_BLT:  btaken = ($signed(opA) < $signed(opB));
            F3_BGE:  btaken = ($signed(opA) >= $signed(opB));
            F3_BLTU: btaken = (opA < opB);
            F3_BGEU: btaken = (opA >= opB);
            // Reserved funct3 is not a branch
            default: begin
              bp_upd = 1'b0;
              is_cf  = 1'b0;
            end
          endcase
          // Mispredict against the counter's direction bit
          pipeflush = bp_upd & (btaken ^ id_bp_predict[1]);
          if (btaken) nxt_pc = id_pc + imm_b;
        end
        OPC_MISCMEM: begin
          if (id_instr == FENCE_I_WORD) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // 2-byte alignment with RVC and 4-byte without
  assign misaligned = HAS_RVC ? nxt_pc[0] : |nxt_pc[1:0];

  ////////////////////////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bu_exception <= '0;
    end else if (!ex_stall) begin
      // Younger instruction is killed by flush or older exception
      if (bu_flush || st_flush || |ex_exception || |mem_exception || |wb_exception) begin
        bu_exception <= '0;
      end else if (!du_stall) begin
        bu_exception <= id_exception;
        bu_exception[CAUSE_MISALIGNED_INSTR] <=
          id_exception[CAUSE_MISALIGNED_INSTR] | (is_cf & misaligned);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Next pc, flushes and history
  ////////////////////////////////////////////////////////////

  // Debug pc stays in force while the debugger holds the core
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_wrote_pc <= 1'b0;
    end else begin
      du_wrote_pc <= du_we_pc | (du_wrote_pc & du_stall);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bu_flush      <= 1'b1;
      bu_cacheflush <= 1'b0;
      bu_nxt_pc     <= PC_INIT;
      bu_bp_update  <= 1'b0;
      bp_history    <= '0;
    end else if (du_we_pc || du_wrote_pc) begin
      // Flush only in the cycle after the write
      bu_flush      <= du_we_pc;
      bu_cacheflush <= 1'b0;
      bu_bp_update  <= 1'b0;
      if (du_we_pc) bu_nxt_pc <= du_dato;
    end else if (!ex_stall) begin
      bu_flush      <= pipeflush & ~du_stall & ~du_flush;
      bu_cacheflush <= cacheflush & ~du_stall & ~du_flush;
      bu_nxt_pc     <= nxt_pc;
      bu_bp_update  <= bp_upd;
      if (bp_upd) bp_history <= {bp_history[BP_GLOBAL_BITS-1:0], btaken};
    end else begin
      // Strobe must not repeat while stalled
      bu_bp_update <= 1'b0;
    end
  end

  // Predictor payload qualified by bu_bp_update
  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      bu_bp_pc      <= id_pc;
      bu_bp_btaken  <= btaken;
      bu_bp_predict <= id_bp_predict;
    end
  end

  // History as seen before the current branch
  assign bu_bp_history = bp_history[BP_GLOBAL_BITS:1];

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Decode hands over a defined word with every real instruction
  a_instr_known: assert property (@(posedge clk) disable iff (!rstn)
    !id_bubble |-> !$isunknown(id_instr));

  a_no_du_we_in_reset: assert property (@(posedge clk) !rstn |-> !du_we_pc);

endmodule

/* branch_predictor/bp_lookup.sv */
`timescale 1ns/10ps

module bp_lookup #(
  parameter int XLEN           = 32,
  parameter int BP_GLOBAL_BITS = 2,
  parameter int PHT_INDEX_BITS = 6
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      if_req,
  input  logic [XLEN-1:0]           if_pc,
  input  logic [BP_GLOBAL_BITS-1:0] bu_bp_history,
  output bu_pkg::bp_cnt_t           if_pred,
  output logic                      if_pred_valid,
  output logic                      lk_req,
  output logic [PHT_INDEX_BITS-1:0] lk_idx,
  input  logic                      lk_gnt,
  input  bu_pkg::bp_cnt_t           pht_rdata
);

  typedef enum logic [1:0] {LK_IDLE, LK_WAIT, LK_DATA} lk_state_t;

  lk_state_t                 state;
  logic [PHT_INDEX_BITS-1:0] idx_hash;
  // Index frozen while the table is busy
  logic [PHT_INDEX_BITS-1:0] idx_q;

  // gshare hash of the word aligned pc
  assign idx_hash = if_pc[PHT_INDEX_BITS+1:2] ^ PHT_INDEX_BITS'(bu_bp_history);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= LK_IDLE;
    end else begin
      case (state)
        LK_IDLE: if (if_req) state <= lk_gnt ? LK_DATA : LK_WAIT;
        LK_WAIT: if (lk_gnt) state <= LK_DATA;
        default: state <= LK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LK_IDLE) idx_q <= idx_hash;
  end

  // No request during the data phase
  assign lk_req        = if_req & (state != LK_DATA);
  assign lk_idx        = (state == LK_WAIT) ? idx_q : idx_hash;
  assign if_pred_valid = (state == LK_DATA);
  assign if_pred       = pht_rdata;

  // Fetch holds its request and pc until the valid pulse
  a_req_held: assert property (@(posedge clk) disable iff (!rstn)
    (state == LK_WAIT) |-> if_req && $stable(if_pc));

endmodule

/* branch_predictor/bp_update.sv */
`timescale 1ns/10ps

module bp_update #(
  parameter int XLEN           = 32,
  parameter int BP_GLOBAL_BITS = 2,
  parameter int PHT_INDEX_BITS = 6
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      bu_bp_update,
  input  logic [XLEN-1:0]           bu_bp_pc,
  input  logic                      bu_bp_btaken,
  input  bu_pkg::bp_cnt_t           bu_bp_predict,
  input  logic [BP_GLOBAL_BITS-1:0] bu_bp_history,
  output logic                      up_req,
  output logic [PHT_INDEX_BITS-1:0] up_idx,
  output bu_pkg::bp_cnt_t           up_wdata,
  input  logic                      up_gnt
);
  import bu_pkg::*;

  bp_cnt_t                   nxt_cnt;
  logic [PHT_INDEX_BITS-1:0] idx_hash;

  // Saturating step from the counter used at prediction
  always_comb begin
    if (bu_bp_btaken) begin
      nxt_cnt = (bu_bp_predict == 2'b11) ? 2'b11 : bu_bp_predict + 2'd1;
    end else begin
      nxt_cnt = (bu_bp_predict == 2'b00) ? 2'b00 : bu_bp_predict - 2'd1;
    end
  end

  // Same hash as the fetch side
  // History here predates the branch
  assign idx_hash = bu_bp_pc[PHT_INDEX_BITS+1:2] ^ PHT_INDEX_BITS'(bu_bp_history);

  ////////////////////////////////////////////////////////////
  // Write request
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      up_req <= 1'b0;
    end else if (bu_bp_update) begin
      up_req <= 1'b1;
    end else if (up_gnt) begin
      up_req <= 1'b0;
    end
  end

  // Payload only, qualified by up_req
  always_ff @(posedge clk) begin
    if (bu_bp_update) begin
      up_idx   <= idx_hash;
      up_wdata <= nxt_cnt;
    end
  end

  // Update port always wins the table
  a_no_overrun: assert property (@(posedge clk) disable iff (!rstn)
    bu_bp_update |-> !(up_req && !up_gnt));

endmodule

/* branch_predictor/pht.sv */
`timescale 1ns/10ps

module pht #(
  parameter int PHT_INDEX_BITS = 6
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      lk_req,
  input  logic [PHT_INDEX_BITS-1:0] lk_idx,
  output logic                      lk_gnt,
  input  logic                      up_req,
  input  logic [PHT_INDEX_BITS-1:0] up_idx,
  input  bu_pkg::bp_cnt_t           up_wdata,
  output logic                      up_gnt,
  output bu_pkg::bp_cnt_t           pht_rdata
);
  import bu_pkg::*;

  bp_cnt_t cnt [2**PHT_INDEX_BITS];

  // Fixed priority with update first
  assign up_gnt = up_req;
  assign lk_gnt = lk_req & ~up_req;

  // Single port write on the granted edge
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 2**PHT_INDEX_BITS; i++) cnt[i] <= BP_CNT_INIT;
    end else if (up_gnt) begin
      cnt[up_idx] <= up_wdata;
    end
  end

  // Read data register valid the cycle after grant
  always_ff @(posedge clk) begin
    if (lk_gnt) pht_rdata <= cnt[lk_idx];
  end

  // A waiting lookup keeps its request and index
  a_lk_hold: assert property (@(posedge clk) disable iff (!rstn)
    lk_req && !lk_gnt |=> lk_req && $stable(lk_idx));

endmodule

/* src/branch_subsys.sv */
`timescale 1ns/10ps

module branch_subsys #(
  parameter int              XLEN           = 32,
  parameter logic [XLEN-1:0] PC_INIT        = 'h200,
  parameter bit              HAS_RVC        = 0,
  parameter int              BP_GLOBAL_BITS = 2,
  parameter int              PHT_INDEX_BITS = 6
) (
  input  logic              clk,
  input  logic              rstn,
  // Pipeline control
  input  logic              ex_stall,
  input  logic              st_flush,
  // Decode stage
  input  logic [XLEN-1:0]   id_pc,
  input  bu_pkg::instr_t    id_instr,
  input  logic              id_bubble,
  input  bu_pkg::bp_cnt_t   id_bp_predict,
  input  logic [XLEN-1:0]   opA,
  input  logic [XLEN-1:0]   opB,
  input  bu_pkg::exc_t      id_exception,
  input  bu_pkg::exc_t      ex_exception,
  input  bu_pkg::exc_t      mem_exception,
  input  bu_pkg::exc_t      wb_exception,
  // Debug unit
  input  logic              du_stall,
  input  logic              du_flush,
  input  logic              du_we_pc,
  input  logic [XLEN-1:0]   du_dato,
  // Resolution results
  output logic [XLEN-1:0]   bu_nxt_pc,
  output logic              bu_flush,
  output logic              bu_cacheflush,
  output bu_pkg::exc_t      bu_exception,
  // Fetch side lookup
  input  logic              if_req,
  input  logic [XLEN-1:0]   if_pc,
  output bu_pkg::bp_cnt_t   if_pred,
  output logic              if_pred_valid
);
  import bu_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  // Branch unit to predictor
  logic                      bu_bp_update;
  logic [XLEN-1:0]           bu_bp_pc;
  logic                      bu_bp_btaken;
  bp_cnt_t                   bu_bp_predict;
  logic [BP_GLOBAL_BITS-1:0] bu_bp_history;

  // Table ports
  logic                      lk_req;
  logic [PHT_INDEX_BITS-1:0] lk_idx;
  logic                      lk_gnt;
  logic                      up_req;
  logic [PHT_INDEX_BITS-1:0] up_idx;
  bp_cnt_t                   up_wdata;
  logic                      up_gnt;
  bp_cnt_t                   pht_rdata;

  branch_unit #(
    .XLEN           (XLEN),
    .PC_INIT        (PC_INIT),
    .HAS_RVC        (HAS_RVC),
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS)
  ) u_branch_unit (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .st_flush      (st_flush),
    .id_pc         (id_pc),
    .id_instr      (id_instr),
    .id_bubble     (id_bubble),
    .id_bp_predict (id_bp_predict),
    .opA           (opA),
    .opB           (opB),
    .id_exception  (id_exception),
    .ex_exception  (ex_exception),
    .mem_exception (mem_exception),
    .wb_exception  (wb_exception),
    .du_stall      (du_stall),
    .du_flush      (du_flush),
    .du_we_pc      (du_we_pc),
    .du_dato       (du_dato),
    .bu_nxt_pc     (bu_nxt_pc),
    .bu_flush      (bu_flush),
    .bu_cacheflush (bu_cacheflush),
    .bu_exception  (bu_exception),
    .bu_bp_update  (bu_bp_update),
    .bu_bp_pc      (bu_bp_pc),
    .bu_bp_btaken  (bu_bp_btaken),
    .bu_bp_predict (bu_bp_predict),
    .bu_bp_history (bu_bp_history)
  );

  bp_lookup #(
    .XLEN           (XLEN),
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS),
    .PHT_INDEX_BITS (PHT_INDEX_BITS)
  ) u_bp_lookup (
    .clk           (clk),
    .rstn          (rstn),
    .if_req        (if_req),
    .if_pc         (if_pc),
    .bu_bp_history (bu_bp_history),
    .if_pred       (if_pred),
    .if_pred_valid (if_pred_valid),
    .lk_req        (lk_req),
    .lk_idx        (lk_idx),
    .lk_gnt        (lk_gnt),
    .pht_rdata     (pht_rdata)
  );

  bp_update #(
    .XLEN           (XLEN),
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS),
    .PHT_INDEX_BITS (PHT_INDEX_BITS)
  ) u_bp_update (
    .clk           (clk),
    .rstn          (rstn),
    .bu_bp_update  (bu_bp_update),
    .bu_bp_pc      (bu_bp_pc),
    .bu_bp_btaken  (bu_bp_btaken),
    .bu_bp_predict (bu_bp_predict),
    .bu_bp_history (bu_bp_history),
    .up_req        (up_req),
    .up_idx        (up_idx),
    .up_wdata      (up_wdata),
    .up_gnt        (up_gnt)
  );

  // Shared counter table
  pht #(
    .PHT_INDEX_BITS (PHT_INDEX_BITS)
  ) u_pht (
    .clk       (clk),
    .rstn      (rstn),
    .lk_req    (lk_req),
    .lk_idx    (lk_idx),
    .lk_gnt    (lk_gnt),
    .up_req    (up_req),
    .up_idx    (up_idx),
    .up_wdata  (up_wdata),
    .up_gnt    (up_gnt),
    .pht_rdata (pht_rdata)
  );

endmodule

/* sim/bu_checker.sv */
`timescale 1ns/10ps

module bu_checker #(
  parameter int XLEN = 32
) (
  input  logic              clk,
  // Strobes from the testbench
  input  logic              chk_bu,
  input  logic              pred_arm,
  input  logic              test_end,
  input  logic [8*24-1:0]   test_name,
  // Expected fields of the current test
  input  logic [XLEN-1:0]   exp_pc,
  input  logic              exp_flush,
  input  logic              exp_cf,
  input  bu_pkg::exc_t      exp_exc,
  input  bu_pkg::bp_cnt_t   exp_pred,
  // DUT outputs
  input  logic [XLEN-1:0]   bu_nxt_pc,
  input  logic              bu_flush,
  input  logic              bu_cacheflush,
  input  bu_pkg::exc_t      bu_exception,
  input  bu_pkg::bp_cnt_t   if_pred,
  input  logic              if_pred_valid,
  // Running totals
  output int                n_tests,
  output int                n_failed,
  output int                n_errors
);

  int test_errs;

  initial begin
    n_tests   = 0;
    n_failed  = 0;
    n_errors  = 0;
    test_errs = 0;
  end

  // One compare, one error line on mismatch
  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error @ %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
      test_errs++;
      n_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling on the falling edge
  ////////////////////////////////////////////////////////////

  // Registered outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    if (chk_bu) begin
      check_value("bu_nxt_pc", 32'(exp_pc), 32'(bu_nxt_pc));
      check_value("bu_flush", 32'(exp_flush), 32'(bu_flush));
      check_value("bu_cacheflush", 32'(exp_cf), 32'(bu_cacheflush));
      check_value("bu_exception", 32'(exp_exc), 32'(bu_exception));
    end
    // Prediction only counts while a lookup is outstanding
    if (if_pred_valid) begin
      if (pred_arm) begin
        check_value("if_pred", 32'(exp_pred), 32'(if_pred));
      end else begin
        $display("Prediction valid at %0t ns with no lookup pending", $time);
        test_errs++;
        n_errors++;
      end
    end
    // Per test summary line
    if (test_end) begin
      n_tests++;
      if (test_errs != 0) begin
        n_failed++;
        $display("%0s : fail, %0d mismatches", test_name, test_errs);
      end else begin
        $display("%0s : pass", test_name);
      end
      test_errs = 0;
    end
  end

endmodule

/* sim/tb_branch_subsys.sv */
`timescale 1ns/10ps

module tb_branch_subsys;
  import bu_pkg::*;

  // Column positions in one vector
  localparam int F_MODE = 0, F_PC = 1, F_INSTR = 2, F_PRED = 3, F_OPA = 4, F_OPB = 5;
  localparam int F_IDEXC = 6, F_KILL = 7, F_STALL = 8, F_DUSTALL = 9, F_DUWE = 10;
  localparam int F_DATO = 11, F_IFPC = 12, F_EPC = 13, F_EFL = 14, F_ECF = 15;
  localparam int F_EEXC = 16, F_EPRED = 17;
  localparam int NF = 18;
  localparam int MAX_VEC = 64;

  logic clk, rstn, ex_stall, st_flush, id_bubble, du_stall, du_flush, du_we_pc;
  logic [31:0] id_pc, opA, opB, du_dato, if_pc, bu_nxt_pc;
  instr_t  id_instr;
  bp_cnt_t id_bp_predict, if_pred;
  exc_t    id_exception, ex_exception, mem_exception, wb_exception, bu_exception;
  logic    bu_flush, bu_cacheflush, if_req, if_pred_valid;

  // Checker side
  logic chk_bu, pred_arm, test_end;
  logic [8*24-1:0] test_name;
  logic [31:0] exp_pc;
  logic exp_flush, exp_cf;
  exc_t exp_exc;
  bp_cnt_t exp_pred;
  int n_tests, n_failed, n_errors;

  logic [31:0]     vec [MAX_VEC][NF];
  logic [8*24-1:0] names [MAX_VEC];
  int n_vec;
  int cycles;
  int limit;

  branch_subsys #(
    .XLEN (32), .PC_INIT (32'h200), .HAS_RVC (0), .BP_GLOBAL_BITS (2), .PHT_INDEX_BITS (6)
  ) u_branch_subsys (
    .clk (clk), .rstn (rstn), .ex_stall (ex_stall), .st_flush (st_flush),
    .id_pc (id_pc), .id_instr (id_instr), .id_bubble (id_bubble),
    .id_bp_predict (id_bp_predict), .opA (opA), .opB (opB),
    .id_exception (id_exception), .ex_exception (ex_exception),
    .mem_exception (mem_exception), .wb_exception (wb_exception),
    .du_stall (du_stall), .du_flush (du_flush), .du_we_pc (du_we_pc), .du_dato (du_dato),
    .bu_nxt_pc (bu_nxt_pc), .bu_flush (bu_flush), .bu_cacheflush (bu_cacheflush),
    .bu_exception (bu_exception), .if_req (if_req), .if_pc (if_pc),
    .if_pred (if_pred), .if_pred_valid (if_pred_valid)
  );

  bu_checker #(.XLEN (32)) u_bu_checker (
    .clk (clk), .chk_bu (chk_bu), .pred_arm (pred_arm), .test_end (test_end),
    .test_name (test_name), .exp_pc (exp_pc), .exp_flush (exp_flush), .exp_cf (exp_cf),
    .exp_exc (exp_exc), .exp_pred (exp_pred), .bu_nxt_pc (bu_nxt_pc), .bu_flush (bu_flush),
    .bu_cacheflush (bu_cacheflush), .bu_exception (bu_exception), .if_pred (if_pred),
    .if_pred_valid (if_pred_valid), .n_tests (n_tests), .n_failed (n_failed),
    .n_errors (n_errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog on cycle count
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Bubble in decode with du_stall left as is
  task automatic idle_inputs();
    id_bubble     <= 1'b1;
    ex_stall      <= 1'b0;
    du_we_pc      <= 1'b0;
    ex_exception  <= '0;
    mem_exception <= '0;
    wb_exception  <= '0;
  endtask

  task automatic load_expected(input int i);
    test_name <= names[i];
    exp_pc    <= vec[i][F_EPC];
    exp_flush <= vec[i][F_EFL][0];
    exp_cf    <= vec[i][F_ECF][0];
    exp_exc   <= exc_t'(vec[i][F_EEXC]);
    exp_pred  <= bp_cnt_t'(vec[i][F_EPRED]);
  endtask

  task automatic reset_test(input int i);
    @(posedge clk);
    test_end <= 1'b0;
    load_expected(i);
    idle_inputs();
    rstn <= 1'b0;
    repeat (3) @(posedge clk);
    rstn   <= 1'b1;
    chk_bu <= 1'b1;
    @(posedge clk);
    chk_bu   <= 1'b0;
    test_end <= 1'b1;
  endtask

  // One decode vector checked one cycle later
  task automatic branch_test(input int i);
    @(posedge clk);
    test_end      <= 1'b0;
    load_expected(i);
    id_pc         <= vec[i][F_PC];
    id_instr      <= vec[i][F_INSTR];
    id_bubble     <= 1'b0;
    id_bp_predict <= bp_cnt_t'(vec[i][F_PRED]);
    opA           <= vec[i][F_OPA];
    opB           <= vec[i][F_OPB];
    id_exception  <= exc_t'(vec[i][F_IDEXC]);
    // Kill column picks the later stage
    ex_exception  <= (vec[i][F_KILL] == 1) ? 16'h0002 : 16'h0000;
    mem_exception <= (vec[i][F_KILL] == 2) ? 16'h0002 : 16'h0000;
    wb_exception  <= (vec[i][F_KILL] == 3) ? 16'h0002 : 16'h0000;
    ex_stall      <= vec[i][F_STALL][0];
    du_stall      <= vec[i][F_DUSTALL][0];
    du_we_pc      <= vec[i][F_DUWE][0];
    du_dato       <= vec[i][F_DATO];
    @(posedge clk);
    idle_inputs();
    chk_bu <= 1'b1;
    @(posedge clk);
    chk_bu <= 1'b0;
  endtask

  // Hold the request until the valid pulse
  task automatic lookup_wait(input int i);
    if_req   <= 1'b1;
    if_pc    <= vec[i][F_IFPC];
    pred_arm <= 1'b1;
    do @(negedge clk); while (!if_pred_valid);
    @(posedge clk);
    if_req   <= 1'b0;
    pred_arm <= 1'b0;
    test_end <= 1'b1;
  endtask

  task automatic read_vectors();
    int fd;
    int cnt;
    string line;
    logic [8*24-1:0] nm;
    logic [31:0] t [NF];
    n_vec = 0;
    fd = $fopen("sim/branch_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file");
    end else begin
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        cnt = $fgets(line, fd);
        // Skip blank and comment lines
        if (cnt > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                        t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9],
                        t[10], t[11], t[12], t[13], t[14], t[15], t[16], t[17]);
          if (cnt == NF + 1) begin
            names[n_vec] = nm;
            for (int k = 0; k < NF; k++) vec[n_vec][k] = t[k];
            n_vec++;
          end else begin
            $display("Malformed vector line skipped: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    cycles = 0;
    limit  = 1000;
    rstn = 1'b0;
    ex_stall = 1'b0;
    st_flush = 1'b0;
    id_pc = '0;
    id_instr = '0;
    id_bubble = 1'b1;
    id_bp_predict = '0;
    opA = '0;
    opB = '0;
    id_exception = '0;
    ex_exception = '0;
    mem_exception = '0;
    wb_exception = '0;
    du_stall = 1'b0;
    du_flush = 1'b0;
    du_we_pc = 1'b0;
    du_dato = '0;
    if_req = 1'b0;
    if_pc = '0;
    chk_bu = 1'b0;
    pred_arm = 1'b0;
    test_end = 1'b0;
    test_name = '0;
    exp_pc = '0;
    exp_flush = 1'b0;
    exp_cf = 1'b0;
    exp_exc = '0;
    exp_pred = '0;
    read_vectors();
    // Worst case a few cycles per vector plus slack
    limit = n_vec * 4 + 20;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < n_vec; i++) begin
      case (vec[i][F_MODE])
        0: reset_test(i);
        1: begin
          branch_test(i);
          test_end <= 1'b1;
        end
        2: begin
          @(posedge clk);
          test_end <= 1'b0;
          load_expected(i);
          lookup_wait(i);
        end
        default: begin
          // Lookup waits while the update holds the table
          branch_test(i);
          lookup_wait(i);
        end
      endcase
    end
    @(posedge clk);
    test_end <= 1'b0;
    @(negedge clk);
    $display("Tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, n_errors);
    if (n_errors == 0 && n_failed == 0 && n_tests == n_vec && n_vec > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim/branch_testdata.txt */
# name mode pc instr pred opa opb id_exc kill stall du_stall du_we du_dato if_pc exp_pc exp_flush exp_cf exp_exc exp_pred
# mode 0 reset, 1 branch unit, 2 lookup, 3 branch plus lookup; kill 1 ex, 2 mem, 3 wb
reset_values 0 0 0 0 0 0 0 0 0 0 0 0 0 200 1 0 0 0
beq_taken 1 1000 00208863 1 5 5 0 0 0 0 0 0 0 1010 1 0 0 0
beq_not 1 1020 00208863 1 5 6 0 0 0 0 0 0 0 1024 0 0 0 0
bne_taken_back 1 1040 FE209CE3 2 1 2 0 0 0 0 0 0 0 1038 0 0 0 0
bne_not 1 1060 00209863 2 7 7 0 0 0 0 0 0 0 1064 1 0 0 0
blt_signed_taken 1 1080 0020C863 3 FFFFFFFF 1 0 0 0 0 0 0 0 1090 0 0 0 0
blt_signed_not 1 10A0 0020C863 0 1 FFFFFFFF 0 0 0 0 0 0 0 10A4 0 0 0 0
bge_signed_taken 1 10C0 0020D863 0 1 FFFFFFFF 0 0 0 0 0 0 0 10D0 1 0 0 0
bge_signed_not 1 10E0 0020D863 3 80000000 0 0 0 0 0 0 0 0 10E4 1 0 0 0
bltu_taken 1 1100 0020E863 2 1 FFFFFFFF 0 0 0 0 0 0 0 1110 0 0 0 0
bltu_not 1 1120 0020E863 2 FFFFFFFF 1 0 0 0 0 0 0 0 1124 1 0 0 0
bgeu_taken 1 1140 0020F863 1 FFFFFFFF 1 0 0 0 0 0 0 0 1150 1 0 0 0
bgeu_not 1 1160 0020F863 1 0 80000000 0 0 0 0 0 0 0 1164 0 0 0 0
bgeu_equal 1 1180 0020F863 2 3 3 0 0 0 0 0 0 0 1190 0 0 0 0
jalr_lsb 1 1200 000080E7 0 2001 4 0 0 0 0 0 0 0 2004 1 0 0 0
jalr_misaligned 1 1220 000080E7 0 3000 2 0 0 0 0 0 0 0 3002 1 0 1 0
jal_noflush 1 1240 100000EF 0 0 0 0 0 0 0 0 0 0 1340 0 0 0 0
fence_i 1 1260 0000100F 0 0 0 0 0 0 0 0 0 0 1264 1 1 0 0
exc_id 1 1280 00000013 0 0 0 4 0 0 0 0 0 0 1284 0 0 4 0
exc_ex_clear 1 12A0 00000013 0 0 0 4 1 0 0 0 0 0 12A4 0 0 0 0
exc_mem_clear 1 12C0 00000013 0 0 0 4 2 0 0 0 0 0 12C4 0 0 0 0
exc_wb_clear 1 12E0 00000013 0 0 0 4 3 0 0 0 0 0 12E4 0 0 0 0
exc_set 1 1300 00000013 0 0 0 4 0 0 0 0 0 0 1304 0 0 4 0
stall_hold 1 1320 000080E7 0 5000 0 0 0 1 0 0 0 0 1304 0 0 4 0
dbg_write 1 1340 100000EF 0 0 0 0 0 0 1 1 8000 0 8000 1 0 0 0
dbg_hold 1 1360 000080E7 0 4000 0 0 0 0 1 0 0 0 8000 0 0 0 0
dbg_release 1 1380 00000013 0 0 0 0 0 0 0 0 0 0 8000 0 0 0 0
jal_after_dbg 1 13A0 100000EF 0 0 0 0 0 0 0 0 0 0 14A0 0 0 0 0
reset_predictor 0 0 0 0 0 0 0 0 0 0 0 0 0 200 1 0 0 0
lookup_init 2 0 0 0 0 0 0 0 0 0 0 0 100 0 0 0 0 1
upd_taken_1 1 100 00208863 1 9 9 0 0 0 0 0 0 0 110 1 0 0 0
upd_taken_2 1 104 00208863 2 9 9 0 0 0 0 0 0 0 114 0 0 0 0
lookup_strong 2 0 0 0 0 0 0 0 0 0 0 0 104 0 0 0 0 3
lookup_with_update 3 108 00208863 1 1 2 0 0 0 0 0 0 108 10C 0 0 0 0

/* branch_subsys.f */
common/bu_pkg.sv
src/branch_unit.sv
branch_predictor/bp_lookup.sv
branch_predictor/bp_update.sv
branch_predictor/pht.sv
src/branch_subsys.sv
sim/bu_checker.sv
sim/tb_branch_subsys.sv
